// ==== hw/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32

// address map, the top nibble picks the region
`define SOC_REGION_MASK 32'hF000_0000
`define SOC_SRAM_BASE   32'h0000_0000
`define SOC_TIMER_BASE  32'h4000_0000

// sram depth in words, indexed by addr[9:2]
`define SOC_SRAM_WORDS  256

`endif

// ==== hw/soc_pkg.sv ====
package soc_pkg;

    // single transfers only, no SEQ or BUSY
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

    // byte offsets inside the timer region
    typedef enum logic [3:0] {
        TMR_CTRL   = 4'h0,
        TMR_CMP    = 4'h4,
        TMR_COUNT  = 4'h8,
        TMR_STATUS = 4'hC
    } timer_reg_e;

endpackage

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [1:0] req_i,
    input  logic [1:0] prio_i,
    input  logic       done_i,
    output logic [1:0] grant_o
);

    soc_pkg::arb_state_e state_q;
    soc_pkg::arb_state_e state_d;
    logic [1:0]          grant_q;
    logic [1:0]          grant_d;
    // index of the master granted last
    logic                last_q;
    logic                last_d;
    logic                winner;

    // lone requester, then single priority, then rotation
    always_comb begin
        if (req_i == 2'b01) begin
            winner = 1'b0;
        end else if (req_i == 2'b10) begin
            winner = 1'b1;
        end else if (prio_i == 2'b01) begin
            winner = 1'b0;
        end else if (prio_i == 2'b10) begin
            winner = 1'b1;
        end else begin
            winner = ~last_q;
        end
    end

    always_comb begin
        state_d = state_q;
        grant_d = grant_q;
        last_d  = last_q;
        case (state_q)
            soc_pkg::ARB_IDLE: begin
                if (|req_i) begin
                    state_d = soc_pkg::ARB_BUSY;
                    grant_d = winner ? 2'b10 : 2'b01;
                    last_d  = winner;
                end
            end
            soc_pkg::ARB_BUSY: begin
                if (done_i) begin
                    state_d = soc_pkg::ARB_IDLE;
                    grant_d = 2'b00;
                end
            end
        endcase
    end

    // fetch counts as last granted out of reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= soc_pkg::ARB_IDLE;
            grant_q <= 2'b00;
            last_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            grant_q <= grant_d;
            last_q  <= last_d;
        end
    end

    assign grant_o = grant_q;

    assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(grant_o));

endmodule

// ==== hw/bus_interconnect.sv ====
`timescale 1ns/1ns
`include "soc_params.svh"

module bus_interconnect (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // fetch port
    input  soc_pkg::htrans_e       if_htrans_i,
    input  logic [`SOC_ADDR_W-1:0] if_haddr_i,
    input  logic                   if_hwrite_i,
    input  logic [`SOC_DATA_W-1:0] if_hwdata_i,
    input  logic                   if_prio_i,
    output logic                   if_hready_o,
    output logic                   if_hresp_o,
    output logic [`SOC_DATA_W-1:0] if_hrdata_o,
    // load-store port
    input  soc_pkg::htrans_e       ls_htrans_i,
    input  logic [`SOC_ADDR_W-1:0] ls_haddr_i,
    input  logic                   ls_hwrite_i,
    input  logic [`SOC_DATA_W-1:0] ls_hwdata_i,
    input  logic                   ls_prio_i,
    output logic                   ls_hready_o,
    output logic                   ls_hresp_o,
    output logic [`SOC_DATA_W-1:0] ls_hrdata_o,
    // slave side
    output logic                   sram_sel_o,
    output logic                   timer_sel_o,
    output logic                   slv_write_o,
    output logic [`SOC_ADDR_W-1:0] slv_addr_o,
    output logic [`SOC_DATA_W-1:0] slv_wdata_o,
    input  logic                   sram_readyout_i,
    input  logic [`SOC_DATA_W-1:0] sram_rdata_i,
    input  logic                   timer_readyout_i,
    input  logic [`SOC_DATA_W-1:0] timer_rdata_i
);

    logic [1:0]             req;
    logic [1:0]             prio;
    logic [1:0]             grant;
    logic                   busy;
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   hit_sram;
    logic                   hit_timer;
    logic                   err_sel;
    logic                   err_wait_q;
    logic                   done;
    logic [`SOC_DATA_W-1:0] rdata;

    assign req[0] = (if_htrans_i == soc_pkg::NONSEQ);
    assign req[1] = (ls_htrans_i == soc_pkg::NONSEQ);
    assign prio   = {ls_prio_i, if_prio_i};

    bus_arbiter u_arbiter (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req),
        .prio_i  (prio),
        .done_i  (done),
        .grant_o (grant)
    );

    // granted master drives the shared slave lines
    assign busy        = |grant;
    assign addr        = grant[1] ? ls_haddr_i : if_haddr_i;
    assign slv_addr_o  = addr;
    assign slv_write_o = grant[1] ? ls_hwrite_i : if_hwrite_i;
    assign slv_wdata_o = grant[1] ? ls_hwdata_i : if_hwdata_i;

    assign hit_sram  = (addr & `SOC_REGION_MASK) == `SOC_SRAM_BASE;
    assign hit_timer = (addr & `SOC_REGION_MASK) == `SOC_TIMER_BASE;

    assign sram_sel_o  = busy & hit_sram;
    assign timer_sel_o = busy & hit_timer;
    assign err_sel     = busy & ~hit_sram & ~hit_timer;

    // unmapped address, answer after one wait cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_wait_q <= 1'b0;
        end else begin
            err_wait_q <= err_sel & ~err_wait_q;
        end
    end

    assign done = sram_readyout_i | timer_readyout_i | err_wait_q;

    // error replies read as zero
    always_comb begin
        if (sram_readyout_i) begin
            rdata = sram_rdata_i;
        end else if (timer_readyout_i) begin
            rdata = timer_rdata_i;
        end else begin
            rdata = '0;
        end
    end

    assign if_hready_o = grant[0] & done;
    assign if_hresp_o  = grant[0] & err_wait_q;
    assign if_hrdata_o = grant[0] ? rdata : '0;
    assign ls_hready_o = grant[1] & done;
    assign ls_hresp_o  = grant[1] & err_wait_q;
    assign ls_hrdata_o = grant[1] ? rdata : '0;

    // completion only after the grant has been held a full cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
        if_hready_o |-> (grant[0] && $past(grant[0])));
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ls_hready_o |-> (grant[1] && $past(grant[1])));

endmodule

// ==== hw/ahb_sram.sv ====
`timescale 1ns/1ns
`include "soc_params.svh"

module ahb_sram (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   sel_i,
    input  logic                   write_i,
    input  logic [`SOC_ADDR_W-1:0] addr_i,
    input  logic [`SOC_DATA_W-1:0] wdata_i,
    output logic                   readyout_o,
    output logic [`SOC_DATA_W-1:0] rdata_o
);

    localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic                   wait_q;
    logic [`SOC_DATA_W-1:0] rdata_q;

    // upper bits inside the region alias
    assign idx = addr_i[IDX_W+1:2];

    // one wait state, readyout the cycle after sel
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= sel_i & ~wait_q;
        end
    end

    // fetch the word during the wait cycle
    always_ff @(posedge clk) begin
        if (sel_i && !wait_q) begin
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i && wait_q && write_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign readyout_o = wait_q;
    assign rdata_o    = rdata_q;

endmodule

// ==== hw/ahb_timer.sv ====
`timescale 1ns/1ns
`include "soc_params.svh"

module ahb_timer (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   sel_i,
    input  logic                   write_i,
    input  logic [`SOC_ADDR_W-1:0] addr_i,
    input  logic [`SOC_DATA_W-1:0] wdata_i,
    output logic                   readyout_o,
    output logic [`SOC_DATA_W-1:0] rdata_o,
    output logic                   timer_irq_o
);

    soc_pkg::timer_reg_e    reg_sel;
    logic                   wait_q;
    logic                   wr_en;
    logic                   match;
    logic                   clr_flag;
    // bit 0 count enable, bit 1 irq enable
    logic [1:0]             ctrl_q;
    logic [`SOC_DATA_W-1:0] cmp_q;
    logic [`SOC_DATA_W-1:0] count_q;
    logic                   flag_q;
    logic [`SOC_DATA_W-1:0] rd_word;
    logic [`SOC_DATA_W-1:0] rdata_q;

    assign reg_sel  = soc_pkg::timer_reg_e'(addr_i[3:0]);
    assign wr_en    = sel_i & wait_q & write_i;
    assign match    = ctrl_q[0] & (count_q == cmp_q);
    assign clr_flag = wr_en & (reg_sel == soc_pkg::TMR_STATUS) & wdata_i[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= sel_i & ~wait_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= 2'b00;
            cmp_q  <= '0;
        end else begin
            if (wr_en && reg_sel == soc_pkg::TMR_CTRL) begin
                ctrl_q <= wdata_i[1:0];
            end
            if (wr_en && reg_sel == soc_pkg::TMR_CMP) begin
                cmp_q <= wdata_i;
            end
        end
    end

    // wrap to zero on compare, a new match beats a clear
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            flag_q  <= 1'b0;
        end else begin
            if (match) begin
                count_q <= '0;
            end else if (ctrl_q[0]) begin
                count_q <= count_q + 1'b1;
            end
            if (match) begin
                flag_q <= 1'b1;
            end else if (clr_flag) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (reg_sel)
            soc_pkg::TMR_CTRL:   rd_word = {{(`SOC_DATA_W-2){1'b0}}, ctrl_q};
            soc_pkg::TMR_CMP:    rd_word = cmp_q;
            soc_pkg::TMR_COUNT:  rd_word = count_q;
            soc_pkg::TMR_STATUS: rd_word = {{(`SOC_DATA_W-1){1'b0}}, flag_q};
            default:             rd_word = '0;
        endcase
    end

    // sampled in the wait cycle like the sram
    always_ff @(posedge clk) begin
        if (sel_i && !wait_q) begin
            rdata_q <= rd_word;
        end
    end

    assign readyout_o  = wait_q;
    assign rdata_o     = rdata_q;
    assign timer_irq_o = flag_q & ctrl_q[1];

    assert property (@(posedge clk) disable iff (!rst_n_i) !ctrl_q[1] |-> !timer_irq_o);

endmodule

// ==== hw/soc_bus_top.sv ====
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_bus_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  soc_pkg::htrans_e       if_htrans_i,
    input  logic [`SOC_ADDR_W-1:0] if_haddr_i,
    input  logic                   if_hwrite_i,
    input  logic [`SOC_DATA_W-1:0] if_hwdata_i,
    input  logic                   if_prio_i,
    output logic                   if_hready_o,
    output logic                   if_hresp_o,
    output logic [`SOC_DATA_W-1:0] if_hrdata_o,
    input  soc_pkg::htrans_e       ls_htrans_i,
    input  logic [`SOC_ADDR_W-1:0] ls_haddr_i,
    input  logic                   ls_hwrite_i,
    input  logic [`SOC_DATA_W-1:0] ls_hwdata_i,
    input  logic                   ls_prio_i,
    output logic                   ls_hready_o,
    output logic                   ls_hresp_o,
    output logic [`SOC_DATA_W-1:0] ls_hrdata_o,
    output logic                   timer_irq_o
);

    logic                   sram_sel;
    logic                   timer_sel;
    logic                   slv_write;
    logic [`SOC_ADDR_W-1:0] slv_addr;
    logic [`SOC_DATA_W-1:0] slv_wdata;
    logic                   sram_readyout;
    logic [`SOC_DATA_W-1:0] sram_rdata;
    logic                   timer_readyout;
    logic [`SOC_DATA_W-1:0] timer_rdata;

    bus_interconnect u_interconnect (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .if_htrans_i      (if_htrans_i),
        .if_haddr_i       (if_haddr_i),
        .if_hwrite_i      (if_hwrite_i),
        .if_hwdata_i      (if_hwdata_i),
        .if_prio_i        (if_prio_i),
        .if_hready_o      (if_hready_o),
        .if_hresp_o       (if_hresp_o),
        .if_hrdata_o      (if_hrdata_o),
        .ls_htrans_i      (ls_htrans_i),
        .ls_haddr_i       (ls_haddr_i),
        .ls_hwrite_i      (ls_hwrite_i),
        .ls_hwdata_i      (ls_hwdata_i),
        .ls_prio_i        (ls_prio_i),
        .ls_hready_o      (ls_hready_o),
        .ls_hresp_o       (ls_hresp_o),
        .ls_hrdata_o      (ls_hrdata_o),
        .sram_sel_o       (sram_sel),
        .timer_sel_o      (timer_sel),
        .slv_write_o      (slv_write),
        .slv_addr_o       (slv_addr),
        .slv_wdata_o      (slv_wdata),
        .sram_readyout_i  (sram_readyout),
        .sram_rdata_i     (sram_rdata),
        .timer_readyout_i (timer_readyout),
        .timer_rdata_i    (timer_rdata)
    );

    ahb_sram u_sram (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sel_i      (sram_sel),
        .write_i    (slv_write),
        .addr_i     (slv_addr),
        .wdata_i    (slv_wdata),
        .readyout_o (sram_readyout),
        .rdata_o    (sram_rdata)
    );

    ahb_timer u_timer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sel_i       (timer_sel),
        .write_i     (slv_write),
        .addr_i      (slv_addr),
        .wdata_i     (slv_wdata),
        .readyout_o  (timer_readyout),
        .rdata_o     (timer_rdata),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// ==== test/tb_soc_bus.sv ====
`timescale 1ns/1ns
`include "soc_params.svh"

module tb_soc_bus;

    // all tests together take a few hundred cycles
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] TMR_BASE = `SOC_TIMER_BASE;

    logic                   clk;
    logic                   rst_n_i;
    soc_pkg::htrans_e       if_htrans_i;
    logic [`SOC_ADDR_W-1:0] if_haddr_i;
    logic                   if_hwrite_i;
    logic [`SOC_DATA_W-1:0] if_hwdata_i;
    logic                   if_prio_i;
    logic                   if_hready_o;
    logic                   if_hresp_o;
    logic [`SOC_DATA_W-1:0] if_hrdata_o;
    soc_pkg::htrans_e       ls_htrans_i;
    logic [`SOC_ADDR_W-1:0] ls_haddr_i;
    logic                   ls_hwrite_i;
    logic [`SOC_DATA_W-1:0] ls_hwdata_i;
    logic                   ls_prio_i;
    logic                   ls_hready_o;
    logic                   ls_hresp_o;
    logic [`SOC_DATA_W-1:0] ls_hrdata_o;
    logic                   timer_irq_o;

    int          seed = 88931;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          cycles;
    logic [31:0] sram_model [256];
    // port index of each completed transfer, 0 fetch and 1 load-store
    int          done_order [$];

    soc_bus_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %0t ns %s expected %0h actual %0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR %0t ns %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // called on a falling edge, returns on the falling edge after completion
    task automatic bus_xfer(input bit port, input bit write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic resp);
        bit got;
        got = 1'b0;
        if (port) begin
            ls_htrans_i = soc_pkg::NONSEQ;
            ls_haddr_i  = addr;
            ls_hwrite_i = write;
            ls_hwdata_i = wdata;
        end else begin
            if_htrans_i = soc_pkg::NONSEQ;
            if_haddr_i  = addr;
            if_hwrite_i = write;
            if_hwdata_i = wdata;
        end
        while (!got) begin
            @(negedge clk);
            if (port ? ls_hready_o : if_hready_o) begin
                rdata = port ? ls_hrdata_o : if_hrdata_o;
                resp  = port ? ls_hresp_o : if_hresp_o;
                done_order.push_back(port);
                got = 1'b1;
            end
        end
        // hold through the completing edge
        @(negedge clk);
        if (port) begin
            ls_htrans_i = soc_pkg::IDLE;
        end else begin
            if_htrans_i = soc_pkg::IDLE;
        end
    endtask

    task automatic bus_write(input bit port, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic resp);
        logic [31:0] unused;
        bus_xfer(port, 1'b1, addr, wdata, unused, resp);
    endtask

    task automatic bus_read(input bit port, input logic [31:0] addr,
                            output logic [31:0] rdata, output logic resp);
        bus_xfer(port, 1'b0, addr, 32'h0, rdata, resp);
    endtask

    task automatic test_sram_round_trip();
        int          err0;
        logic [7:0]  idx [16];
        logic [31:0] data;
        logic [31:0] rdata;
        logic        resp;
        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            idx[i] = $random(seed);
            data   = $random(seed);
            bus_write(1'b1, {22'd0, idx[i], 2'b00}, data, resp);
            sram_model[idx[i]] = data;
            if (resp !== 1'b0) report_mismatch("ls_hresp_o", 0, resp);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(1'b0, {22'd0, idx[i], 2'b00}, rdata, resp);
            if (rdata !== sram_model[idx[i]]) begin
                report_mismatch("if_hrdata_o", sram_model[idx[i]], rdata);
            end
            if (resp !== 1'b0) report_mismatch("if_hresp_o", 0, resp);
        end
        end_test("sram round trip", err0);
    endtask

    task automatic test_error_response();
        int          err0;
        logic [31:0] rdata;
        logic        resp;
        err0 = errors;
        bus_write(1'b1, 32'h0000_0020, 32'hA5A5_0F0F, resp);
        sram_model[8] = 32'hA5A5_0F0F;
        bus_read(1'b1, 32'h7000_0020, rdata, resp);
        if (resp !== 1'b1) report_mismatch("ls_hresp_o", 1, resp);
        if (rdata !== 32'h0) report_mismatch("ls_hrdata_o", 0, rdata);
        bus_xfer(1'b0, 1'b1, 32'h7000_0020, 32'hDEAD_BEEF, rdata, resp);
        if (resp !== 1'b1) report_mismatch("if_hresp_o", 1, resp);
        if (rdata !== 32'h0) report_mismatch("if_hrdata_o", 0, rdata);
        // same low bits in sram must be untouched
        bus_read(1'b0, 32'h0000_0020, rdata, resp);
        if (rdata !== sram_model[8]) report_mismatch("if_hrdata_o", sram_model[8], rdata);
        end_test("error response", err0);
    endtask

    task automatic test_priority();
        int          err0;
        logic [31:0] rdata;
        logic        resp;
        logic        resp_if;
        logic        resp_ls;
        err0 = errors;
        done_order.delete();
        if_prio_i = 1'b1;
        ls_prio_i = 1'b0;
        fork
            bus_write(1'b0, 32'h0000_0040, 32'h1111_2222, resp_if);
            bus_write(1'b1, 32'h0000_0040, 32'h3333_4444, resp_ls);
        join
        if_prio_i = 1'b0;
        if (done_order.size() != 2 || done_order[0] != 0) begin
            report_problem("fetch port with priority was not served first");
        end
        if (resp_if !== 1'b0) report_mismatch("if_hresp_o", 0, resp_if);
        if (resp_ls !== 1'b0) report_mismatch("ls_hresp_o", 0, resp_ls);
        sram_model[16] = 32'h3333_4444;
        // fetch port read leaves fetch as last granted
        bus_read(1'b0, 32'h0000_0040, rdata, resp);
        if (rdata !== sram_model[16]) report_mismatch("if_hrdata_o", sram_model[16], rdata);
        end_test("priority", err0);
    endtask

    task automatic test_tie_rotation();
        int   err0;
        int   expected [4] = '{1, 0, 1, 0};
        logic resp_if;
        logic resp_ls;
        err0 = errors;
        done_order.delete();
        fork
            begin
                bus_write(1'b1, 32'h0000_0080, 32'hAAAA_0001, resp_ls);
                bus_write(1'b1, 32'h0000_0084, 32'hAAAA_0002, resp_ls);
            end
            begin
                bus_write(1'b0, 32'h0000_0088, 32'hBBBB_0001, resp_if);
                bus_write(1'b0, 32'h0000_008C, 32'hBBBB_0002, resp_if);
            end
        join
        if (done_order.size() != 4) begin
            report_problem("wrong number of completed transfers in tie rotation");
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (done_order[i] != expected[i]) begin
                    report_problem($sformatf("tie served wrong port at slot %0d", i));
                end
            end
        end
        if (resp_if !== 1'b0) report_mismatch("if_hresp_o", 0, resp_if);
        if (resp_ls !== 1'b0) report_mismatch("ls_hresp_o", 0, resp_ls);
        end_test("tie rotation", err0);
    endtask

    task automatic test_timer_irq();
        int          err0;
        int          waited;
        bit          seen;
        logic [31:0] rdata;
        logic        resp;
        err0 = errors;
        bus_write(1'b1, TMR_BASE + 32'h4, 32'd20, resp);
        bus_write(1'b1, TMR_BASE + 32'h0, 32'h3, resp);
        waited = 0;
        while (timer_irq_o !== 1'b1 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (timer_irq_o !== 1'b1) report_problem("timer_irq_o did not rise within 40 cycles");
        bus_read(1'b1, TMR_BASE + 32'h8, rdata, resp);
        if (rdata > 32'd20) begin
            $display("FAIL %0t ns ls_hrdata_o expected <= 20 actual %0d", $time, rdata);
            errors++;
        end
        bus_write(1'b1, TMR_BASE + 32'hC, 32'h1, resp);
        if (timer_irq_o !== 1'b0) report_mismatch("timer_irq_o", 0, timer_irq_o);
        // counting on, interrupt masked
        bus_write(1'b1, TMR_BASE + 32'h0, 32'h1, resp);
        bus_write(1'b1, TMR_BASE + 32'hC, 32'h1, resp);
        seen = 1'b0;
        repeat (60) begin
            @(negedge clk);
            if (timer_irq_o !== 1'b0) seen = 1'b1;
        end
        if (seen) report_problem("timer_irq_o rose with the interrupt disabled");
        bus_read(1'b1, TMR_BASE + 32'hC, rdata, resp);
        if (rdata !== 32'h1) report_mismatch("ls_hrdata_o", 1, rdata);
        bus_write(1'b1, TMR_BASE + 32'h0, 32'h0, resp);
        end_test("timer interrupt", err0);
    endtask

    initial begin
        if_htrans_i = soc_pkg::IDLE;
        if_haddr_i  = '0;
        if_hwrite_i = 1'b0;
        if_hwdata_i = '0;
        if_prio_i   = 1'b0;
        ls_htrans_i = soc_pkg::IDLE;
        ls_haddr_i  = '0;
        ls_hwrite_i = 1'b0;
        ls_hwdata_i = '0;
        ls_prio_i   = 1'b0;
        rst_n_i     = 1'b0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        cycles      = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        test_sram_round_trip();
        test_error_response();
        test_priority();
        test_tie_rotation();
        test_timer_irq();
        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/bus_interconnect.sv
hw/ahb_sram.sv
hw/ahb_timer.sv
hw/soc_bus_top.sv
test/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_pkg.sv
      - hw/bus_arbiter.sv
      - hw/bus_interconnect.sv
      - hw/ahb_sram.sv
      - hw/ahb_timer.sv
      - hw/soc_bus_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - test/tb_soc_bus.sv
